/* verilog/poly_pkg.sv */
package poly_pkg;

	// sizes.
	localparam int DATA_W = 16;
	localparam int PROD_W = 2 * DATA_W;
	localparam int RED_CNT_W = 5;
	localparam int COEFF_DEPTH = 1024;
	localparam int COEFF_AW = 10;
	localparam int RESULT_DEPTH = 32;
	localparam int RESULT_AW = 5;
	localparam int MOD_COUNT = 8;
	localparam int MOD_AW = 3;
	localparam int DEG_W = 3;

	// wishbone port widths.
	localparam int WB_AW = 16;
	localparam int WB_DW = 32;
	localparam int WB_SW = 4;

	// word offsets inside the register window at word address bits [11:0].
	localparam logic [11:0] REG_CTRL = 12'h000;
	localparam logic [11:0] REG_X = 12'h001;
	localparam logic [11:0] REG_C = 12'h002;
	localparam logic [11:0] REG_CFG = 12'h003;
	localparam logic [11:0] REG_BASE = 12'h004;
	localparam logic [11:0] MOD_BASE = 12'h008;

	// window select in word address bits [13:12].
	localparam logic [1:0] REG_WIN = 2'b00;
	localparam logic [1:0] COEFF_WIN = 2'b10;
	localparam logic [1:0] RESULT_WIN = 2'b11;

	// cfg fields and status bits.
	localparam int CFG_DEG_LSB = 0;
	localparam int CFG_CNT_LSB = 8;
	localparam int CFG_MOD_LSB = 16;
	localparam int ST_BUSY = 0;
	localparam int ST_DONE = 1;
	localparam int ST_ERR = 2;

	// batch sequencer states.
	localparam logic [2:0] B_START = 3'd0;
	localparam logic [2:0] B_LAUNCH = 3'd1;
	localparam logic [2:0] B_WAIT = 3'd2;
	localparam logic [2:0] B_STORE = 3'd3;
	localparam logic [2:0] B_CHECK = 3'd4;
	localparam logic [2:0] B_END = 3'd5;

	// evaluator states.
	localparam logic [2:0] P_IDLE = 3'd0;
	localparam logic [2:0] P_FETCH = 3'd1;
	localparam logic [2:0] P_LOAD = 3'd2;
	localparam logic [2:0] P_MAC = 3'd3;
	localparam logic [2:0] P_RED = 3'd4;
	localparam logic [2:0] P_ADDC = 3'd5;
	localparam logic [2:0] P_FINAL = 3'd6;

endpackage

/* verilog/dual_port_ram.sv */
`timescale 1ns/1ns

module dual_port_ram
#(
	parameter int WIDTH = 16,
	parameter int DEPTH = 1024
)
(
	input logic clk,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_addr,
	input logic [WIDTH-1:0] wr_data,
	input logic rd_en,
	input logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0] rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// read data holds until the next read.
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* verilog/mod_reducer.sv */
`timescale 1ns/1ns

module mod_reducer
	import poly_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic red_start,
	input logic [PROD_W-1:0] value,
	input logic [DATA_W-1:0] modulus,
	output logic red_done,
	output logic [DATA_W-1:0] remainder
);

	logic running;
	logic [RED_CNT_W-1:0] bit_cnt;
	logic last_step;
	logic [PROD_W-1:0] dividend;
	logic [DATA_W-1:0] divisor;
	logic [DATA_W-1:0] rem;
	logic [DATA_W:0] trial;

	// shift in the next dividend bit.
	assign trial = {rem, dividend[PROD_W-1]};
	assign last_step = running && (bit_cnt == RED_CNT_W'(PROD_W - 1));
	assign remainder = rem;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			running <= 1'b0;
			bit_cnt <= '0;
			red_done <= 1'b0;
		end
		else
		begin
			red_done <= last_step;
			if (red_start)
			begin
				running <= 1'b1;
				bit_cnt <= '0;
			end
			else if (running)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (last_step)
					running <= 1'b0;
			end
		end
	end

	// restoring step that subtracts when the trial value fits.
	always_ff @(posedge clk)
	begin
		if (red_start)
		begin
			dividend <= value;
			divisor <= modulus;
			rem <= '0;
		end
		else if (running)
		begin
			dividend <= dividend << 1;
			if (trial >= {1'b0, divisor})
				rem <= DATA_W'(trial - {1'b0, divisor});
			else
				rem <= trial[DATA_W-1:0];
		end
	end

endmodule

/* verilog/poly_eval.sv */
`timescale 1ns/1ns

module poly_eval
	import poly_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start_poly,
	input logic [COEFF_AW-1:0] poly_addr,
	input logic [DEG_W-1:0] degree,
	input logic [DATA_W-1:0] x,
	input logic [DATA_W-1:0] c,
	input logic [DATA_W-1:0] modulus,
	output logic coeff_rd_en,
	output logic [COEFF_AW-1:0] coeff_rd_addr,
	input logic [DATA_W-1:0] coeff_rd_data,
	output logic done_poly,
	output logic [DATA_W-1:0] poly_result
);

	logic [2:0] state;
	// offset of the coefficient last folded into acc.
	logic [DEG_W-1:0] cnt;
	logic [COEFF_AW-1:0] base;
	logic [DATA_W-1:0] acc;
	logic red_start;
	logic red_done;
	logic [PROD_W-1:0] red_value;
	logic [DATA_W-1:0] remainder;

	mod_reducer u_reducer
	(
		.clk(clk),
		.rst(rst),
		.red_start(red_start),
		.value(red_value),
		.modulus(modulus),
		.red_done(red_done),
		.remainder(remainder)
	);

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= P_IDLE;
			cnt <= '0;
			coeff_rd_en <= 1'b0;
			red_start <= 1'b0;
			done_poly <= 1'b0;
		end
		else
		begin
			coeff_rd_en <= 1'b0;
			red_start <= 1'b0;
			done_poly <= 1'b0;
			case (state)
				P_IDLE:
					if (start_poly)
					begin
						cnt <= degree;
						coeff_rd_en <= 1'b1;
						state <= P_FETCH;
					end
				P_FETCH:
				begin
					// second read overlaps the first.
					coeff_rd_en <= (cnt != '0);
					state <= P_LOAD;
				end
				P_LOAD:
					state <= (cnt == '0) ? P_ADDC : P_MAC;
				P_MAC:
				begin
					// prefetch the next lower coefficient during the reduction.
					red_start <= 1'b1;
					cnt <= cnt - 1'b1;
					coeff_rd_en <= (cnt > DEG_W'(1));
					state <= P_RED;
				end
				P_RED:
					if (red_done)
						state <= (cnt == '0) ? P_ADDC : P_MAC;
				P_ADDC:
				begin
					red_start <= 1'b1;
					state <= P_FINAL;
				end
				P_FINAL:
					if (red_done)
					begin
						done_poly <= 1'b1;
						state <= P_IDLE;
					end
				default:
					state <= P_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			P_IDLE:
				if (start_poly)
				begin
					base <= poly_addr;
					coeff_rd_addr <= poly_addr + COEFF_AW'(degree);
				end
			P_FETCH:
				coeff_rd_addr <= base + COEFF_AW'(cnt) - COEFF_AW'(1);
			P_LOAD:
				acc <= coeff_rd_data;
			P_MAC:
			begin
				red_value <= PROD_W'(acc) * PROD_W'(x) + PROD_W'(coeff_rd_data);
				coeff_rd_addr <= base + COEFF_AW'(cnt) - COEFF_AW'(2);
			end
			P_RED:
				if (red_done)
					acc <= remainder;
			P_ADDC:
				red_value <= PROD_W'(acc) + PROD_W'(c);
			P_FINAL:
				if (red_done)
					poly_result <= remainder;
			default:
				;
		endcase
	end

endmodule

/* verilog/batch_eval.sv */
`timescale 1ns/1ns

module batch_eval
	import poly_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [DEG_W-1:0] degree,
	input logic [RESULT_AW-1:0] count,
	input logic [COEFF_AW-1:0] base,
	input logic [DATA_W-1:0] x,
	input logic [DATA_W-1:0] c,
	input logic [DATA_W-1:0] modulus,
	output logic busy,
	output logic done_batch,
	output logic err,
	output logic res_wr_en,
	output logic [RESULT_AW-1:0] res_wr_addr,
	output logic [DATA_W-1:0] res_wr_data,
	output logic coeff_rd_en,
	output logic [COEFF_AW-1:0] coeff_rd_addr,
	input logic [DATA_W-1:0] coeff_rd_data
);

	logic [2:0] state;
	logic [RESULT_AW-1:0] idx;
	logic [COEFF_AW-1:0] poly_addr;
	logic start_poly;
	logic done_poly;
	logic [DATA_W-1:0] poly_result;

	poly_eval u_poly
	(
		.clk(clk),
		.rst(rst),
		.start_poly(start_poly),
		.poly_addr(poly_addr),
		.degree(degree),
		.x(x),
		.c(c),
		.modulus(modulus),
		.coeff_rd_en(coeff_rd_en),
		.coeff_rd_addr(coeff_rd_addr),
		.coeff_rd_data(coeff_rd_data),
		.done_poly(done_poly),
		.poly_result(poly_result)
	);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= B_START;
			idx <= '0;
			busy <= 1'b0;
			done_batch <= 1'b0;
			err <= 1'b0;
			start_poly <= 1'b0;
			res_wr_en <= 1'b0;
		end
		else
		begin
			done_batch <= 1'b0;
			start_poly <= 1'b0;
			res_wr_en <= 1'b0;
			case (state)
				B_START:
					if (start)
					begin
						// a zero modulus ends the batch at once.
						busy <= 1'b1;
						idx <= '0;
						err <= (modulus == '0);
						state <= (modulus == '0) ? B_END : B_LAUNCH;
					end
				B_LAUNCH:
				begin
					start_poly <= 1'b1;
					state <= B_WAIT;
				end
				B_WAIT:
					if (done_poly)
						state <= B_STORE;
				B_STORE:
				begin
					res_wr_en <= 1'b1;
					state <= B_CHECK;
				end
				B_CHECK:
					if (idx == count)
						state <= B_END;
					else
					begin
						idx <= idx + 1'b1;
						state <= B_LAUNCH;
					end
				B_END:
				begin
					busy <= 1'b0;
					done_batch <= 1'b1;
					state <= B_START;
				end
				default:
					state <= B_START;
			endcase
		end
	end

	// next polynomial starts degree + 1 words further on.
	always_ff @(posedge clk)
	begin
		case (state)
			B_START:
				if (start)
					poly_addr <= base;
			B_WAIT:
				if (done_poly)
				begin
					res_wr_data <= poly_result;
					res_wr_addr <= idx;
				end
			B_CHECK:
				poly_addr <= poly_addr + COEFF_AW'(degree) + COEFF_AW'(1);
			default:
				;
		endcase
	end

endmodule

/* verilog/wb_regs.sv */
`timescale 1ns/1ns

module wb_regs
	import poly_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_AW-1:0] wb_adr,
	input logic [WB_DW-1:0] wb_dat_w,
	input logic [WB_SW-1:0] wb_sel,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic wb_ack,
	input logic busy,
	input logic done_batch,
	input logic err,
	output logic start,
	output logic [DATA_W-1:0] x,
	output logic [DATA_W-1:0] c,
	output logic [DEG_W-1:0] degree,
	output logic [RESULT_AW-1:0] count,
	output logic [COEFF_AW-1:0] base,
	output logic [DATA_W-1:0] modulus,
	output logic coeff_wr_en,
	output logic [COEFF_AW-1:0] coeff_wr_addr,
	output logic [DATA_W-1:0] coeff_wr_data,
	output logic res_rd_en,
	output logic [RESULT_AW-1:0] res_rd_addr,
	input logic [DATA_W-1:0] res_rd_data
);

	logic req;
	logic wr;
	logic cfg_wr;
	logic [1:0] win;
	logic [11:0] off;
	logic is_mod;
	logic [WB_DW-1:0] mask;
	logic [WB_DW-1:0] status;
	logic [WB_DW-1:0] cur;
	logic [WB_DW-1:0] merged;
	logic [WB_DW-1:0] rd_q;
	logic rd_res;
	logic done_q;
	logic err_q;
	logic [MOD_AW-1:0] mod_idx;
	logic [DATA_W-1:0] mod_tab [MOD_COUNT];

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------
	// ack is held off for one cycle so each strobe acks once.
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign wr = req & wb_we;
	assign win = wb_adr[15:14];
	assign off = wb_adr[13:2];
	assign is_mod = (off[11:MOD_AW] == MOD_BASE[11:MOD_AW]);
	assign cfg_wr = wr & ~busy & (win == REG_WIN);
	assign mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};

	assign coeff_wr_en = wr & ~busy & (win == COEFF_WIN) & (&wb_sel[1:0]);
	assign coeff_wr_addr = off[COEFF_AW-1:0];
	assign coeff_wr_data = wb_dat_w[DATA_W-1:0];
	assign res_rd_en = req & ~wb_we & (win == RESULT_WIN);
	assign res_rd_addr = off[RESULT_AW-1:0];
	assign modulus = mod_tab[mod_idx];

	// result ram data arrives in the ack cycle.
	assign wb_dat_r = rd_res ? WB_DW'(res_rd_data) : rd_q;

	always_comb
	begin
		status = '0;
		status[ST_BUSY] = busy;
		status[ST_DONE] = done_q;
		status[ST_ERR] = err_q;
		cur = '0;
		if (is_mod)
			cur[DATA_W-1:0] = mod_tab[off[MOD_AW-1:0]];
		else
			case (off)
				REG_CTRL: cur = status;
				REG_X: cur[DATA_W-1:0] = x;
				REG_C: cur[DATA_W-1:0] = c;
				REG_CFG:
				begin
					cur[CFG_DEG_LSB +: DEG_W] = degree;
					cur[CFG_CNT_LSB +: RESULT_AW] = count;
					cur[CFG_MOD_LSB +: MOD_AW] = mod_idx;
				end
				REG_BASE: cur[COEFF_AW-1:0] = base;
				default: ;
			endcase
		merged = (cur & ~mask) | (wb_dat_w & mask);
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			x <= '0;
			c <= '0;
			degree <= '0;
			count <= '0;
			mod_idx <= '0;
			base <= '0;
		end
		else if (cfg_wr && !is_mod)
			case (off)
				REG_X: x <= merged[DATA_W-1:0];
				REG_C: c <= merged[DATA_W-1:0];
				REG_CFG:
				begin
					degree <= merged[CFG_DEG_LSB +: DEG_W];
					count <= merged[CFG_CNT_LSB +: RESULT_AW];
					mod_idx <= merged[CFG_MOD_LSB +: MOD_AW];
				end
				REG_BASE: base <= merged[COEFF_AW-1:0];
				default: ;
			endcase
	end

	always_ff @(posedge clk)
	begin
		if (cfg_wr && is_mod)
			mod_tab[off[MOD_AW-1:0]] <= merged[DATA_W-1:0];
		if (req && !wb_we)
			rd_q <= (win == REG_WIN) ? cur : '0;
	end

	// handshake, start pulse and sticky status.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wb_ack <= 1'b0;
			rd_res <= 1'b0;
			start <= 1'b0;
			done_q <= 1'b0;
			err_q <= 1'b0;
		end
		else
		begin
			wb_ack <= req;
			rd_res <= res_rd_en;
			start <= cfg_wr & (off == REG_CTRL) & wb_sel[0] & wb_dat_w[0];
			if (start)
			begin
				done_q <= 1'b0;
				err_q <= 1'b0;
			end
			else if (done_batch)
			begin
				done_q <= 1'b1;
				err_q <= err;
			end
		end
	end

endmodule

/* verilog/poly_accel_top.sv */
`timescale 1ns/1ns

module poly_accel_top
	import poly_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [WB_AW-1:0] wb_adr,
	input logic [WB_DW-1:0] wb_dat_w,
	input logic [WB_SW-1:0] wb_sel,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic wb_ack
);

	logic start;
	logic busy;
	logic done_batch;
	logic err;
	logic [DATA_W-1:0] x;
	logic [DATA_W-1:0] c;
	logic [DATA_W-1:0] modulus;
	logic [DEG_W-1:0] degree;
	logic [RESULT_AW-1:0] count;
	logic [COEFF_AW-1:0] base;

	// coefficient buffer that software writes and the evaluator reads.
	logic coeff_wr_en;
	logic [COEFF_AW-1:0] coeff_wr_addr;
	logic [DATA_W-1:0] coeff_wr_data;
	logic coeff_rd_en;
	logic [COEFF_AW-1:0] coeff_rd_addr;
	logic [DATA_W-1:0] coeff_rd_data;

	// result buffer that the sequencer writes and software reads.
	logic res_wr_en;
	logic [RESULT_AW-1:0] res_wr_addr;
	logic [DATA_W-1:0] res_wr_data;
	logic res_rd_en;
	logic [RESULT_AW-1:0] res_rd_addr;
	logic [DATA_W-1:0] res_rd_data;

	wb_regs u_regs (.*);

	batch_eval u_batch (.*);

	dual_port_ram
	#(
		.WIDTH(DATA_W),
		.DEPTH(COEFF_DEPTH)
	)
	u_coeff_ram
	(
		.clk(clk),
		.wr_en(coeff_wr_en),
		.wr_addr(coeff_wr_addr),
		.wr_data(coeff_wr_data),
		.rd_en(coeff_rd_en),
		.rd_addr(coeff_rd_addr),
		.rd_data(coeff_rd_data)
	);

	dual_port_ram
	#(
		.WIDTH(DATA_W),
		.DEPTH(RESULT_DEPTH)
	)
	u_result_ram
	(
		.clk(clk),
		.wr_en(res_wr_en),
		.wr_addr(res_wr_addr),
		.wr_data(res_wr_data),
		.rd_en(res_rd_en),
		.rd_addr(res_rd_addr),
		.rd_data(res_rd_data)
	);

endmodule

/* verification/tb_poly_tasks.svh */
`ifndef TB_POLY_TASKS_SVH
`define TB_POLY_TASKS_SVH

localparam int ACK_LIMIT = 16;
localparam int DONE_LIMIT = 4000;

function automatic logic [WB_AW-1:0] byte_addr(input logic [1:0] win, input logic [11:0] off);
	return {win, off, 2'b00};
endfunction

// 32-bit lcg whose upper half is the random word.
function automatic logic [DATA_W-1:0] next_rand();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[31:16];
endfunction

// horner's rule from the top coefficient with a reduction after every step.
function automatic logic [DATA_W-1:0] ref_poly(input int first, input int deg,
	input longint px, input longint pc, input longint m);
	longint acc;
	int k;
	acc = coeff_img[(first + deg) % COEFF_DEPTH];
	for (k = deg - 1; k >= 0; k--)
		acc = (acc * px + coeff_img[(first + k) % COEFF_DEPTH]) % m;
	return DATA_W'((acc + pc) % m);
endfunction

// ------------------------------------------------------------
// wishbone master
// ------------------------------------------------------------
task automatic wait_ack();
	int n;
	n = 0;
	@(negedge clk);
	while (!wb_ack && n < ACK_LIMIT)
	begin
		@(negedge clk);
		n++;
	end
	if (!wb_ack)
		abort_run("no wishbone ack arrived within the timeout");
endtask

task automatic write_word(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = 1'b1;
	wb_adr = adr;
	wb_dat_w = data;
	wb_sel = 4'hf;
	wait_ack();
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
endtask

task automatic read_word(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = 1'b0;
	wb_adr = adr;
	wb_sel = 4'hf;
	wait_ack();
	data = wb_dat_r;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
endtask

// ------------------------------------------------------------
// accelerator helpers
// ------------------------------------------------------------
task automatic put_coeff(input int addr, input logic [DATA_W-1:0] value);
	write_word(byte_addr(COEFF_WIN, 12'(addr % COEFF_DEPTH)), WB_DW'(value));
	coeff_img[addr % COEFF_DEPTH] = value;
endtask

task automatic set_modulus(input int idx, input logic [DATA_W-1:0] m);
	write_word(byte_addr(REG_WIN, MOD_BASE + 12'(idx)), WB_DW'(m));
	mod_img[idx] = m;
endtask

task automatic start_batch(input logic [DATA_W-1:0] px, input logic [DATA_W-1:0] pc,
	input int deg, input int n, input int midx, input int first);
	logic [WB_DW-1:0] cfg;
	cfg = '0;
	cfg[CFG_DEG_LSB +: DEG_W] = DEG_W'(deg);
	cfg[CFG_CNT_LSB +: RESULT_AW] = RESULT_AW'(n - 1);
	cfg[CFG_MOD_LSB +: MOD_AW] = MOD_AW'(midx);
	write_word(byte_addr(REG_WIN, REG_X), WB_DW'(px));
	write_word(byte_addr(REG_WIN, REG_C), WB_DW'(pc));
	write_word(byte_addr(REG_WIN, REG_CFG), cfg);
	write_word(byte_addr(REG_WIN, REG_BASE), WB_DW'(first));
	write_word(byte_addr(REG_WIN, REG_CTRL), 32'h1);
endtask

// status polling until the batch is done and idle.
task automatic poll_done(output logic [WB_DW-1:0] status);
	int n;
	n = 0;
	read_word(byte_addr(REG_WIN, REG_CTRL), status);
	while ((status[ST_BUSY] || !status[ST_DONE]) && n < DONE_LIMIT)
	begin
		read_word(byte_addr(REG_WIN, REG_CTRL), status);
		n++;
	end
	if (status[ST_BUSY] || !status[ST_DONE])
		abort_run("the batch did not finish within the timeout");
endtask

task automatic check_results(input int first, input int deg, input int n,
	input logic [DATA_W-1:0] px, input logic [DATA_W-1:0] pc, input logic [DATA_W-1:0] m);
	logic [WB_DW-1:0] rd;
	logic [DATA_W-1:0] expected;
	int j;
	for (j = 0; j < n; j++)
	begin
		expected = ref_poly(first + j * (deg + 1), deg, px, pc, m);
		read_word(byte_addr(RESULT_WIN, 12'(j)), rd);
		check_value($sformatf("result %0d", j), WB_DW'(expected), rd);
	end
endtask

`endif

/* verification/tb_poly_accel.sv */
`timescale 1ns/1ns

module tb_poly_accel
	import poly_pkg::*;
();

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_AW-1:0] wb_adr;
	logic [WB_DW-1:0] wb_dat_w;
	logic [WB_SW-1:0] wb_sel;
	logic [WB_DW-1:0] wb_dat_r;
	logic wb_ack;

	logic [31:0] lcg_state = 32'd74;
	logic [DATA_W-1:0] coeff_img [COEFF_DEPTH];
	logic [DATA_W-1:0] mod_img [MOD_COUNT];
	logic [DATA_W-1:0] saved_res [6];
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_ok = 0;
	int test_errors = 0;
	int batch_count = 0;
	string test_name = "";

	poly_accel_top u_dut
	(
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_sel(wb_sel),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// count completed batches on the falling edge.
	always @(negedge clk)
		if (rst && u_dut.done_batch)
			batch_count++;

	// ------------------------------------------------------------
	// wishbone handshake
	// ------------------------------------------------------------
	assert property (@(posedge clk) disable iff (!rst) $rose(wb_cyc && wb_stb) |=> wb_ack)
	else
	begin
		errors = errors + 1;
		$display("%s: wishbone ack did not follow the strobe by one cycle", test_name);
	end

	assert property (@(posedge clk) disable iff (!rst) wb_ack |=> !wb_ack)
	else
	begin
		errors = errors + 1;
		$display("%s: wishbone ack stayed high for more than one cycle", test_name);
	end

	assert property (@(posedge clk) disable iff (!rst) wb_ack |-> $past(wb_cyc && wb_stb))
	else
	begin
		errors = errors + 1;
		$display("%s: wishbone ack came without a strobe", test_name);
	end

	// ------------------------------------------------------------
	// checking and bookkeeping
	// ------------------------------------------------------------
	task automatic check_value(input string what, input logic [WB_DW-1:0] expected,
		input logic [WB_DW-1:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors = errors + 1;
			$display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == test_errors)
		begin
			tests_ok++;
			$display("%s: ok", test_name);
		end
		else
			$display("%s: not ok, %0d errors", test_name, errors - test_errors);
	endtask

	task automatic abort_run(input string why);
		$display("%s: %s", test_name, why);
		$display("test failed");
		$finish;
	endtask

	`include "tb_poly_tasks.svh"

	initial
	begin
		logic [WB_DW-1:0] rd;
		logic [WB_DW-1:0] st;
		logic [DATA_W-1:0] px;
		logic [DATA_W-1:0] pc;
		int first;
		int midx;
		int batches_before;
		int i;
		rst = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		repeat (10) @(negedge clk);
		rst = 1'b1;

		start_test("reset_status");
		read_word(byte_addr(REG_WIN, REG_CTRL), rd);
		check_value("status", '0, rd);
		read_word(byte_addr(REG_WIN, REG_X), rd);
		check_value("x", '0, rd);
		read_word(byte_addr(REG_WIN, REG_CFG), rd);
		check_value("cfg", '0, rd);
		finish_test();

		start_test("single_poly");
		put_coeff(0, 16'd3);
		put_coeff(1, 16'd5);
		put_coeff(2, 16'd7);
		put_coeff(3, 16'd2);
		set_modulus(0, 16'd101);
		start_batch(16'd4, 16'd9, 3, 1, 0, 0);
		poll_done(st);
		check_value("status", 32'd1 << ST_DONE, st);
		check_results(0, 3, 1, 16'd4, 16'd9, 16'd101);
		finish_test();

		// six polynomials that wrap past the end of the buffer.
		start_test("random_batch");
		for (i = 0; i < MOD_COUNT; i++)
			set_modulus(i, next_rand() | 16'h1);
		midx = 1 + next_rand() % 7;
		first = 1000 + next_rand() % 16;
		for (i = 0; i < 48; i++)
			put_coeff(first + i, next_rand());
		px = next_rand();
		pc = next_rand();
		start_batch(px, pc, 7, 6, midx, first);
		poll_done(st);
		check_value("status", 32'd1 << ST_DONE, st);
		check_results(first, 7, 6, px, pc, mod_img[midx]);
		for (i = 0; i < 6; i++)
			saved_res[i] = ref_poly(first + i * 8, 7, px, pc, mod_img[midx]);
		finish_test();

		start_test("zero_modulus");
		set_modulus(midx, 16'd0);
		start_batch(px, pc, 7, 6, midx, first);
		poll_done(st);
		check_value("status", (32'd1 << ST_DONE) | (32'd1 << ST_ERR), st);
		for (i = 0; i < 6; i++)
		begin
			read_word(byte_addr(RESULT_WIN, 12'(i)), rd);
			check_value($sformatf("result %0d", i), WB_DW'(saved_res[i]), rd);
		end
		finish_test();

		// x write and second start land while the batch runs.
		start_test("busy_lock");
		set_modulus(2, next_rand() | 16'h1);
		first = 200;
		for (i = 0; i < 12; i++)
			put_coeff(first + i, next_rand());
		px = next_rand();
		pc = next_rand();
		batches_before = batch_count;
		start_batch(px, pc, 2, 4, 2, first);
		write_word(byte_addr(REG_WIN, REG_X), WB_DW'(~px));
		write_word(byte_addr(REG_WIN, REG_CTRL), 32'h1);
		poll_done(st);
		check_value("status", 32'd1 << ST_DONE, st);
		check_results(first, 2, 4, px, pc, mod_img[2]);
		read_word(byte_addr(REG_WIN, REG_X), rd);
		check_value("x", WB_DW'(px), rd);
		read_word(byte_addr(REG_WIN, REG_CTRL), rd);
		check_value("final status", 32'd1 << ST_DONE, rd);
		check_value("batches", WB_DW'(batches_before + 1), WB_DW'(batch_count));
		finish_test();

		start_test("degree_zero");
		set_modulus(3, 16'd50);
		put_coeff(60, 16'd30);
		start_batch(16'd7, 16'd40, 0, 1, 3, 60);
		poll_done(st);
		check_value("status", 32'd1 << ST_DONE, st);
		check_results(60, 0, 1, 16'd7, 16'd40, 16'd50);
		set_modulus(4, 16'hfff1);
		put_coeff(61, 16'hffff);
		start_batch(16'd7, 16'hffff, 0, 1, 4, 61);
		poll_done(st);
		check_value("status", 32'd1 << ST_DONE, st);
		check_results(61, 0, 1, 16'd7, 16'hffff, 16'hfff1);
		finish_test();

		$display("tests ok: %0d of %0d, checks: %0d, errors: %0d",
			tests_ok, tests_run, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+verification
verilog/poly_pkg.sv
verilog/dual_port_ram.sv
verilog/mod_reducer.sv
verilog/poly_eval.sv
verilog/batch_eval.sv
verilog/wb_regs.sv
verilog/poly_accel_top.sv
verification/tb_poly_accel.sv

/* Bender.yml */
package:
  name: poly_accel

sources:
  - verilog/poly_pkg.sv
  - verilog/dual_port_ram.sv
  - verilog/mod_reducer.sv
  - verilog/poly_eval.sv
  - verilog/batch_eval.sv
  - verilog/wb_regs.sv
  - verilog/poly_accel_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_poly_accel.sv
